// File: rv_disasm.f
+incdir+sim
hdl/rv_disasm_pkg.sv
hdl/reg_abi_name.sv
hdl/opcode_classify.sv
hdl/operand_extract.sv
hdl/rv_disasm_top.sv
sim/tb_rv_disasm.sv

// File: Bender.yml
package:
  name: rv_disasm

sources:
  - files:
      - hdl/rv_disasm_pkg.sv
      - hdl/reg_abi_name.sv
      - hdl/opcode_classify.sv
      - hdl/operand_extract.sv
      - hdl/rv_disasm_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_disasm.sv

// File: sim/tb_rv_disasm_model.svh
`ifndef TB_RV_DISASM_MODEL_SVH
`define TB_RV_DISASM_MODEL_SVH

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (expected !== actual) begin
    $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
    error_count++;
  end
endtask

// text is packed left to right and padded with spaces.
function automatic logic [63:0] pad_text(input string s, input int chars);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < chars; i++) begin
    v = v << 8;
    if (i < s.len())
      v[7:0] = s[i];
    else
      v[7:0] = " ";
  end
  return v;
endfunction

function automatic string abi_name(input int n);
  string s;
  case (n)
    0: s = "zero";
    1: s = "ra";
    2: s = "sp";
    3: s = "gp";
    4: s = "tp";
    default: begin
      if (n <= 7)
        s = $sformatf("t%0d", n - 5);
      else if (n <= 9)
        s = $sformatf("s%0d", n - 8);
      else if (n <= 17)
        s = $sformatf("a%0d", n - 10);
      else if (n <= 27)
        s = $sformatf("s%0d", n - 16);
      else
        s = $sformatf("t%0d", n - 25);
    end
  endcase
  return s;
endfunction

function automatic string alu_name(input logic [2:0] f3, input logic alt, input logic is_imm);
  string s;
  case (f3)
    3'd0:    s = (alt && !is_imm) ? "sub" : "add";
    3'd1:    s = "sll";
    3'd2:    s = "slt";
    3'd3:    s = "slt";
    3'd4:    s = "xor";
    3'd5:    s = alt ? "sra" : "srl";
    3'd6:    s = "or";
    default: s = "and";
  endcase
  if (is_imm)
    s = {s, "i"};
  if (f3 == 3'd3)
    s = {s, "u"};
  return s;
endfunction

function automatic void disasm_ref(input instr_t w, output mnemonic_t mn,
                                   output reg_name_t rd_n, output reg_name_t rs1_n,
                                   output reg_name_t rs2_n, output imm_t imm_v,
                                   output disasm_flag_t flag_v, output logic ill);
  logic [6:0]    opc;
  logic [2:0]    f3;
  logic [6:0]    f7;
  logic [12:0]   imm13;
  logic [20:0]   imm21;
  logic [3:0]    pres;
  string         name;
  string         size;
  instr_format_t fmt;
  logic          legal;
  logic          sgn;
  logic          brk;
  logic          ld;
  logic          diff;
  opc   = w[6:0];
  f3    = w[14:12];
  f7    = w[31:25];
  fmt   = FMT_ILLEGAL;
  name  = "";
  legal = 1'b1;
  sgn   = 1'b1;
  brk   = 1'b0;
  ld    = 1'b0;
  diff  = 1'b0;
  size  = (f3[1:0] == 2'd0) ? "b" : ((f3[1:0] == 2'd1) ? "h" : "w");
  case (opc)
    OPC_OP: begin
      fmt   = FMT_R;
      name  = alu_name(f3, f7[5], 1'b0);
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
    end
    OPC_OP_IMM: begin
      fmt  = FMT_I;
      name = alu_name(f3, f7[5], 1'b1);
      sgn  = !((f3 == 3'd1) || (f3 == 3'd3) || (f3 == 3'd5));
      if (f3 == 3'd1)
        legal = (f7 == 7'h00);
      if (f3 == 3'd5)
        legal = (f7 == 7'h00) || (f7 == 7'h20);
    end
    OPC_LOAD: begin
      fmt   = FMT_I;
      brk   = 1'b1;
      ld    = 1'b1;
      name  = f3[2] ? {"l", size, "u"} : {"l", size};
      legal = (f3[1:0] != 2'd3) && (f3 != 3'd6);
    end
    OPC_STORE: begin
      fmt   = FMT_S;
      brk   = 1'b1;
      name  = {"s", size};
      legal = (f3 < 3'd3);
    end
    OPC_BRANCH: begin
      fmt   = FMT_SB;
      sgn   = (f3 < 3'd6);
      legal = (f3 != 3'd2) && (f3 != 3'd3);
      case (f3)
        3'd0:    name = "beq";
        3'd1:    name = "bne";
        3'd4:    name = "blt";
        3'd5:    name = "bge";
        3'd6:    name = "bltu";
        default: name = "bgeu";
      endcase
    end
    OPC_LUI: begin
      fmt  = FMT_U;
      name = "lui";
    end
    OPC_AUIPC: begin
      fmt  = FMT_U;
      name = "auipc";
    end
    OPC_JAL: begin
      fmt  = FMT_UJ;
      name = "jal";
    end
    OPC_JALR: begin
      fmt   = FMT_I;
      brk   = 1'b1;
      name  = "jalr";
      legal = (f3 == 3'd0);
    end
    OPC_SYSTEM: begin
      fmt   = FMT_I;
      diff  = 1'b1;
      name  = w[20] ? "ebreak" : "ecall";
      legal = (w[31:21] == '0) && (w[19:7] == '0);
    end
    default: legal = 1'b0;
  endcase

  // I and S carry the sign bit into bit 12 so every short immediate is 13 bits wide.
  case (fmt)
    FMT_I:   imm13 = {w[31], w[31:20]};
    FMT_S:   imm13 = {w[31], w[31:25], w[11:7]};
    FMT_SB:  imm13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    default: imm13 = '0;
  endcase
  imm21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
  if (fmt == FMT_U)
    imm_v = {w[31:12], 12'h000};
  else if (fmt == FMT_UJ)
    imm_v = sgn ? {{11{imm21[20]}}, imm21} : {11'b0, imm21};
  else if (fmt == FMT_R)
    imm_v = '0;
  else
    imm_v = sgn ? {{19{imm13[12]}}, imm13} : {19'b0, imm13};

  case (fmt)
    FMT_R:          pres = PRESENCE_R;
    FMT_I:          pres = PRESENCE_I;
    FMT_S, FMT_SB:  pres = PRESENCE_S;
    default:        pres = PRESENCE_U;
  endcase
  if (diff)
    pres = 4'b0000;

  rd_n   = reg_name_t'(pad_text(abi_name(w[11:7]), 4));
  rs1_n  = reg_name_t'(pad_text(abi_name(w[19:15]), 4));
  rs2_n  = reg_name_t'(pad_text(abi_name(w[24:20]), 4));
  mn     = mnemonic_t'(pad_text(name, 6));
  flag_v = {ld, brk, sgn, diff, pres};
  ill    = 1'b0;
  if (!legal) begin
    mn     = mnemonic_t'(pad_text("unimp", 6));
    imm_v  = '0;
    flag_v = '0;
    ill    = 1'b1;
  end
endfunction

////////////////////////////////////////////////////////////
// instruction encoders
////////////////////////////////////////////////////////////

function automatic instr_t enc_r(input logic [6:0] f7, input reg_num_t rs2, input reg_num_t rs1,
                                 input logic [2:0] f3, input reg_num_t rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm12, input reg_num_t rs1,
                                 input logic [2:0] f3, input reg_num_t rd, input logic [6:0] opc);
  return {imm12, rs1, f3, rd, opc};
endfunction

function automatic instr_t enc_s(input logic [11:0] imm12, input reg_num_t rs2,
                                 input reg_num_t rs1, input logic [2:0] f3);
  return {imm12[11:5], rs2, rs1, f3, imm12[4:0], OPC_STORE};
endfunction

function automatic instr_t enc_b(input logic [12:0] imm13, input reg_num_t rs2,
                                 input reg_num_t rs1, input logic [2:0] f3);
  return {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], OPC_BRANCH};
endfunction

function automatic instr_t enc_j(input logic [20:0] imm21, input reg_num_t rd);
  return {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, OPC_JAL};
endfunction

`endif

// File: sim/tb_rv_disasm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_disasm import rv_disasm_pkg::*; ();

  logic         clk = 1'b0;
  logic         rst_n;
  logic         instr_valid;
  instr_t       instr;
  logic         out_valid;
  mnemonic_t    mnemonic;
  reg_name_t    rd_name;
  reg_name_t    rs1_name;
  reg_name_t    rs2_name;
  imm_t         imm;
  disasm_flag_t flag;
  logic         illegal;

  integer     seed = 73;
  int         error_count = 0;
  int         checked_count = 0;
  int         cycle_count = 0;
  int         cycle_limit = 1000;
  logic       timed_out = 1'b0;
  logic [1:0] valid_hist = 2'b00;
  instr_t     stim_q[$];
  int         gap_q[$];
  instr_t     exp_q[$];

  `include "tb_rv_disasm_model.svh"

  rv_disasm_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .out_valid   (out_valid),
    .mnemonic    (mnemonic),
    .rd_name     (rd_name),
    .rs1_name    (rs1_name),
    .rs2_name    (rs2_name),
    .imm         (imm),
    .flag        (flag),
    .illegal     (illegal)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic reg_num_t rand_reg();
    int r;
    r = $random(seed);
    return r[4:0];
  endfunction

  // about one word in eight is followed by a short idle gap.
  function automatic int random_gap();
    int r;
    r = $random(seed);
    if (r[2:0] == 3'd0)
      return 1 + r[4:3];
    return 0;
  endfunction

  function automatic logic [6:0] pick_opcode(input int sel);
    case (sel)
      0:       return OPC_OP;
      1:       return OPC_OP_IMM;
      2:       return OPC_LOAD;
      3:       return OPC_STORE;
      4:       return OPC_BRANCH;
      5:       return OPC_LUI;
      6:       return OPC_AUIPC;
      7:       return OPC_JAL;
      8:       return OPC_JALR;
      9:       return OPC_SYSTEM;
      default: return 7'b0001111;
    endcase
  endfunction

  task automatic queue_word(input instr_t w, input int gap);
    stim_q.push_back(w);
    gap_q.push_back(gap);
  endtask

  task automatic build_stimulus();
    logic [11:0] imm12;
    instr_t      w;
    int          r;
    for (int k = 0; k < 3; k++) begin
      for (int op = 0; op < 10; op++) begin
        queue_word(enc_r((op < 8) ? 7'h00 : 7'h20, rand_reg(), rand_reg(),
                         (op < 8) ? 3'(op) : ((op == 8) ? 3'd0 : 3'd5), rand_reg(), OPC_OP),
                   random_gap());
      end
    end
    for (int k = 0; k < 4; k++) begin
      for (int f = 0; f < 8; f++) begin
        imm12 = $random(seed);
        if ((f == 1) || (f == 5))
          imm12[11:5] = ((f == 5) && k[0]) ? 7'h20 : 7'h00;
        queue_word(enc_i(imm12, rand_reg(), 3'(f), rand_reg(), OPC_OP_IMM), random_gap());
      end
    end
    queue_word(enc_i(12'hfff, rand_reg(), 3'd0, rand_reg(), OPC_OP_IMM), 0);
    queue_word(enc_i(12'hffb, rand_reg(), 3'd3, rand_reg(), OPC_OP_IMM), 0);
    queue_word(enc_i(12'h800, rand_reg(), 3'd2, rand_reg(), OPC_OP_IMM), 0);
    for (int k = 0; k < 3; k++) begin
      for (int f = 0; f < 6; f++) begin
        if (f != 3)
          queue_word(enc_i(12'($random(seed)), rand_reg(), 3'(f), rand_reg(), OPC_LOAD),
                     random_gap());
      end
      queue_word(enc_i(12'($random(seed)), rand_reg(), 3'd0, rand_reg(), OPC_JALR), 0);
      for (int f = 0; f < 3; f++)
        queue_word(enc_s(12'($random(seed)), rand_reg(), rand_reg(), 3'(f)), random_gap());
      for (int f = 0; f < 8; f++) begin
        if ((f != 2) && (f != 3))
          queue_word(enc_b(13'($random(seed)), rand_reg(), rand_reg(), 3'(f)), random_gap());
      end
      queue_word({20'($random(seed)), rand_reg(), OPC_LUI}, random_gap());
      queue_word({20'($random(seed)), rand_reg(), OPC_AUIPC}, random_gap());
      queue_word(enc_j(21'($random(seed)), rand_reg()), random_gap());
    end
    queue_word(enc_b(13'h1ff0, rand_reg(), rand_reg(), 3'd6), 0);
    queue_word(enc_j(21'h1ff800, rand_reg()), 0);

    // ecall and ebreak, then words that must be reported as illegal.
    queue_word(32'h0000_0073, 0);
    queue_word(32'h0010_0073, 1);
    queue_word(32'h0000_000f, 0);
    queue_word(32'h3000_2573, 0);
    queue_word(32'h0000_0473, 0);
    queue_word(32'h0000_4501, 0);
    queue_word(enc_r(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg(), OPC_OP), 0);
    queue_word(enc_r(7'h20, rand_reg(), rand_reg(), 3'd1, rand_reg(), OPC_OP), 0);
    queue_word(enc_i({7'h20, 5'd3}, rand_reg(), 3'd1, rand_reg(), OPC_OP_IMM), 0);
    queue_word(enc_i(12'h010, rand_reg(), 3'd3, rand_reg(), OPC_LOAD), 0);
    queue_word(enc_i(12'h010, rand_reg(), 3'd1, rand_reg(), OPC_JALR), 0);
    queue_word(enc_b(13'h0020, rand_reg(), rand_reg(), 3'd2), 2);

    // one long back-to-back burst of mixed words.
    for (int k = 0; k < 48; k++) begin
      w      = $random(seed);
      r      = $random(seed);
      w[6:0] = pick_opcode(r[3:0]);
      queue_word(w, 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and end of run
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    build_stimulus();
    cycle_limit = 2 * stim_q.size() + 50;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= stim_q[i];
      exp_q.push_back(stim_q[i]);
      for (int g = 0; g < gap_q[i]; g++) begin
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= $random(seed);
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    while ((exp_q.size() != 0) && !timed_out)
      @(posedge clk);
    repeat (3) @(posedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d words were sent but never came out", exp_q.size());
      error_count++;
    end
    $display("Summary: %0d words checked, %0d errors", checked_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if ((cycle_count >= cycle_limit) && !timed_out) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      error_count++;
      timed_out = 1'b1;
    end
  end

  // outputs settle after the rising edge, so they are compared on the falling edge.
  always @(negedge clk) begin : compare
    instr_t       w;
    mnemonic_t    e_mn;
    reg_name_t    e_rd;
    reg_name_t    e_rs1;
    reg_name_t    e_rs2;
    imm_t         e_imm;
    disasm_flag_t e_flag;
    logic         e_ill;
    check_value("out_valid", valid_hist[1], out_valid);
    valid_hist = {valid_hist[0], instr_valid};
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid was high at time %0t with no word waiting", $time);
        error_count++;
      end else begin
        w = exp_q.pop_front();
        disasm_ref(w, e_mn, e_rd, e_rs1, e_rs2, e_imm, e_flag, e_ill);
        check_value("mnemonic", e_mn, mnemonic);
        check_value("rd_name", e_rd, rd_name);
        check_value("rs1_name", e_rs1, rs1_name);
        check_value("rs2_name", e_rs2, rs2_name);
        check_value("imm", e_imm, imm);
        check_value("flag", e_flag, flag);
        check_value("illegal", e_ill, illegal);
        checked_count++;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_disasm_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_disasm_top import rv_disasm_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         instr_valid,
  input  instr_t       instr,
  output logic         out_valid,
  output mnemonic_t    mnemonic,
  output reg_name_t    rd_name,
  output reg_name_t    rs1_name,
  output reg_name_t    rs2_name,
  output imm_t         imm,
  output disasm_flag_t flag,
  output logic         illegal
);

  instr_format_t format_c;
  disasm_flag_t  in_flag_c;
  mnemonic_t     mnemonic_c;
  logic          illegal_c;

  logic          valid_s1;
  instr_t        instr_s1;
  instr_format_t format_s1;
  disasm_flag_t  in_flag_s1;
  mnemonic_t     mnemonic_s1;
  logic          illegal_s1;

  reg_name_t     rd_name_c;
  reg_name_t     rs1_name_c;
  reg_name_t     rs2_name_c;
  imm_t          imm_c;
  disasm_flag_t  flag_c;

  ////////////////////////////////////////////////////////////
  // stage 1: classify
  ////////////////////////////////////////////////////////////

  opcode_classify u_classify (
    .instr    (instr),
    .format   (format_c),
    .in_flag  (in_flag_c),
    .mnemonic (mnemonic_c),
    .illegal  (illegal_c)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1    <= 1'b0;
      instr_s1    <= '0;
      format_s1   <= '0;
      in_flag_s1  <= '0;
      mnemonic_s1 <= '0;
      illegal_s1  <= 1'b0;
    end else begin
      valid_s1 <= instr_valid;
      if (instr_valid) begin
        instr_s1    <= instr;
        format_s1   <= format_c;
        in_flag_s1  <= in_flag_c;
        mnemonic_s1 <= mnemonic_c;
        illegal_s1  <= illegal_c;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 2: operands
  ////////////////////////////////////////////////////////////

  operand_extract u_extract (
    .instr    (instr_s1),
    .format   (format_s1),
    .in_flag  (in_flag_s1),
    .rd_name  (rd_name_c),
    .rs1_name (rs1_name_c),
    .rs2_name (rs2_name_c),
    .imm      (imm_c),
    .flag     (flag_c)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      mnemonic  <= '0;
      rd_name   <= '0;
      rs1_name  <= '0;
      rs2_name  <= '0;
      imm       <= '0;
      flag      <= '0;
      illegal   <= 1'b0;
    end else begin
      out_valid <= valid_s1;
      if (valid_s1) begin
        mnemonic <= mnemonic_s1;
        rd_name  <= rd_name_c;
        rs1_name <= rs1_name_c;
        rs2_name <= rs2_name_c;
        imm      <= imm_c;
        flag     <= flag_c;
        illegal  <= illegal_s1;
      end
    end
  end

  // each accepted word leaves exactly two edges later.
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == ($past(instr_valid, 2) && $past(rst_n, 1) && $past(rst_n, 2)))
    else $error("rv_disasm_top: out_valid does not follow instr_valid by two cycles");

endmodule

`default_nettype wire

// File: hdl/operand_extract.sv
`timescale 1ns/1ps
`default_nettype none

module operand_extract import rv_disasm_pkg::*; (
  input  instr_t        instr,
  input  instr_format_t format,
  input  disasm_flag_t  in_flag,
  output reg_name_t     rd_name,
  output reg_name_t     rs1_name,
  output reg_name_t     rs2_name,
  output imm_t          imm,
  output disasm_flag_t  flag
);

  logic [FLAG_IMM_INDEX:FLAG_RD_INDEX] default_mask;
  logic [FLAG_IMM_INDEX:FLAG_RD_INDEX] presence;
  logic [12:0]                         imm13;
  logic [20:0]                         imm21;
  logic                                legal;
  logic                                sign_ext;

  reg_abi_name u_rd_name (
    .reg_num  (instr[11:7]),
    .reg_name (rd_name)
  );

  reg_abi_name u_rs1_name (
    .reg_num  (instr[19:15]),
    .reg_name (rs1_name)
  );

  reg_abi_name u_rs2_name (
    .reg_num  (instr[24:20]),
    .reg_name (rs2_name)
  );

  ////////////////////////////////////////////////////////////
  // per-format operand layout
  ////////////////////////////////////////////////////////////

  always_comb begin
    default_mask = '0;
    imm13        = '0;
    imm21        = '0;
    legal        = 1'b1;
    case (format)
      FMT_R: default_mask = PRESENCE_R;
      FMT_I: begin
        default_mask = PRESENCE_I;
        imm13        = {instr[31], instr[31:20]};
      end
      FMT_S: begin
        default_mask = PRESENCE_S;
        imm13        = {instr[31], instr[31:25], instr[11:7]};
      end
      FMT_SB: begin
        default_mask = PRESENCE_S;
        imm13        = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      FMT_U: default_mask = PRESENCE_U;
      FMT_UJ: begin
        default_mask = PRESENCE_U;
        imm21        = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  assign sign_ext = in_flag[FLAG_SIGNED_INDEX];

  // the classifier narrows the mask only when it flags a difference.
  assign presence = in_flag[FLAG_DIFF_INDEX] ?
                    (default_mask & in_flag[FLAG_IMM_INDEX:FLAG_RD_INDEX]) : default_mask;

  always_comb begin
    case (format)
      FMT_I, FMT_S, FMT_SB: imm = {{(IMM_W-13){imm13[12] & sign_ext}}, imm13};
      FMT_U:                imm = {instr[31:12], 12'b0};
      FMT_UJ:               imm = {{(IMM_W-21){imm21[20] & sign_ext}}, imm21};
      default:              imm = '0;
    endcase
  end

  always_comb begin
    flag = '0;
    if (legal) begin
      flag[FLAG_IMM_INDEX:FLAG_RD_INDEX] = presence;
      flag[FLAG_DIFF_INDEX]              = in_flag[FLAG_DIFF_INDEX];
      flag[FLAG_SIGNED_INDEX]            = in_flag[FLAG_SIGNED_INDEX];
      flag[FLAG_BRACKET_INDEX]           = in_flag[FLAG_BRACKET_INDEX];
      flag[FLAG_LOAD_INDEX]              = in_flag[FLAG_LOAD_INDEX];
    end
  end

  // a legal word without an override must print at least one operand.
  always_comb begin
    assert final ((in_flag[FLAG_DIFF_INDEX] !== 1'b0) || (format === FMT_ILLEGAL) ||
                  (flag[FLAG_IMM_INDEX:FLAG_RD_INDEX] != '0))
      else $error("operand_extract: no operand for format %0d", format);
  end

endmodule

`default_nettype wire

// File: hdl/opcode_classify.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_classify import rv_disasm_pkg::*; (
  input  instr_t        instr,
  output instr_format_t format,
  output disasm_flag_t  in_flag,
  output mnemonic_t     mnemonic,
  output logic          illegal
);

  logic [OPCODE_W-1:0] opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  instr_format_t fmt;
  mnemonic_t     mn;
  logic          known;
  logic          is_signed;
  logic          is_bracket;
  logic          is_load;
  logic          is_diff;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    fmt        = FMT_ILLEGAL;
    mn         = MNEMONIC_UNIMP;
    known      = 1'b1;
    is_signed  = 1'b1;
    is_bracket = 1'b0;
    is_load    = 1'b0;
    is_diff    = 1'b0;
    case (opcode)
      OPC_OP: begin
        fmt   = FMT_R;
        // only sub and sra may set funct7 bit 5.
        known = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        case (funct3)
          3'b000:  mn = funct7[5] ? "sub   " : "add   ";
          3'b001:  mn = "sll   ";
          3'b010:  mn = "slt   ";
          3'b011:  mn = "sltu  ";
          3'b100:  mn = "xor   ";
          3'b101:  mn = funct7[5] ? "sra   " : "srl   ";
          3'b110:  mn = "or    ";
          default: mn = "and   ";
        endcase
      end
      OPC_OP_IMM: begin
        fmt = FMT_I;
        case (funct3)
          3'b000: mn = "addi  ";
          3'b010: mn = "slti  ";
          3'b011: begin
            mn        = "sltiu ";
            is_signed = 1'b0;
          end
          3'b100: mn = "xori  ";
          3'b110: mn = "ori   ";
          3'b111: mn = "andi  ";
          3'b001: begin
            mn        = "slli  ";
            is_signed = 1'b0;
            known     = (funct7 == 7'b0000000);
          end
          default: begin
            mn        = funct7[5] ? "srai  " : "srli  ";
            is_signed = 1'b0;
            known     = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      OPC_LOAD: begin
        fmt        = FMT_I;
        is_bracket = 1'b1;
        is_load    = 1'b1;
        case (funct3)
          3'b000:  mn = "lb    ";
          3'b001:  mn = "lh    ";
          3'b010:  mn = "lw    ";
          3'b100:  mn = "lbu   ";
          3'b101:  mn = "lhu   ";
          default: known = 1'b0;
        endcase
      end
      OPC_STORE: begin
        fmt        = FMT_S;
        is_bracket = 1'b1;
        case (funct3)
          3'b000:  mn = "sb    ";
          3'b001:  mn = "sh    ";
          3'b010:  mn = "sw    ";
          default: known = 1'b0;
        endcase
      end
      OPC_BRANCH: begin
        fmt = FMT_SB;
        case (funct3)
          3'b000: mn = "beq   ";
          3'b001: mn = "bne   ";
          3'b100: mn = "blt   ";
          3'b101: mn = "bge   ";
          3'b110: begin
            mn        = "bltu  ";
            is_signed = 1'b0;
          end
          3'b111: begin
            mn        = "bgeu  ";
            is_signed = 1'b0;
          end
          default: known = 1'b0;
        endcase
      end
      OPC_LUI: begin
        fmt = FMT_U;
        mn  = "lui   ";
      end
      OPC_AUIPC: begin
        fmt = FMT_U;
        mn  = "auipc ";
      end
      OPC_JAL: begin
        fmt = FMT_UJ;
        mn  = "jal   ";
      end
      OPC_JALR: begin
        fmt        = FMT_I;
        mn         = "jalr  ";
        is_bracket = 1'b1;
        known      = (funct3 == 3'b000);
      end
      OPC_SYSTEM: begin
        // ecall and ebreak print no operands at all.
        fmt     = FMT_I;
        is_diff = 1'b1;
        mn      = instr[20] ? "ebreak" : "ecall ";
        known   = (instr[31:21] == '0) && (instr[19:7] == '0);
      end
      default: known = 1'b0;
    endcase
  end

  always_comb begin
    in_flag = '0;
    if (known) begin
      format                      = fmt;
      mnemonic                    = mn;
      illegal                     = 1'b0;
      in_flag[FLAG_DIFF_INDEX]    = is_diff;
      in_flag[FLAG_SIGNED_INDEX]  = is_signed;
      in_flag[FLAG_BRACKET_INDEX] = is_bracket;
      in_flag[FLAG_LOAD_INDEX]    = is_load;
    end else begin
      format   = FMT_ILLEGAL;
      mnemonic = MNEMONIC_UNIMP;
      illegal  = 1'b1;
    end
  end

  // every decoded word must also carry a real format.
  always_comb begin
    assert final (illegal == (format == FMT_ILLEGAL))
      else $error("opcode_classify: illegal bit %0b disagrees with format %0d", illegal, format);
  end

endmodule

`default_nettype wire

// File: hdl/reg_abi_name.sv
`timescale 1ns/1ps
`default_nettype none

module reg_abi_name import rv_disasm_pkg::*; (
  input  reg_num_t  reg_num,
  output reg_name_t reg_name
);

  // names are padded on the right so the formatter can trim them.
  always_comb begin
    case (reg_num)
      5'd0:    reg_name = "zero";
      5'd1:    reg_name = "ra  ";
      5'd2:    reg_name = "sp  ";
      5'd3:    reg_name = "gp  ";
      5'd4:    reg_name = "tp  ";
      5'd5:    reg_name = "t0  ";
      5'd6:    reg_name = "t1  ";
      5'd7:    reg_name = "t2  ";
      5'd8:    reg_name = "s0  ";
      5'd9:    reg_name = "s1  ";
      5'd10:   reg_name = "a0  ";
      5'd11:   reg_name = "a1  ";
      5'd12:   reg_name = "a2  ";
      5'd13:   reg_name = "a3  ";
      5'd14:   reg_name = "a4  ";
      5'd15:   reg_name = "a5  ";
      5'd16:   reg_name = "a6  ";
      5'd17:   reg_name = "a7  ";
      5'd18:   reg_name = "s2  ";
      5'd19:   reg_name = "s3  ";
      5'd20:   reg_name = "s4  ";
      5'd21:   reg_name = "s5  ";
      5'd22:   reg_name = "s6  ";
      5'd23:   reg_name = "s7  ";
      5'd24:   reg_name = "s8  ";
      5'd25:   reg_name = "s9  ";
      5'd26:   reg_name = "s10 ";
      5'd27:   reg_name = "s11 ";
      5'd28:   reg_name = "t3  ";
      5'd29:   reg_name = "t4  ";
      5'd30:   reg_name = "t5  ";
      default: reg_name = "t6  ";
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_disasm_pkg.sv
`default_nettype none

package rv_disasm_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int INSTR_W        = 32;
  localparam int FORMAT_W       = 3;
  localparam int REG_NUM_W      = 5;
  localparam int REG_NAME_CHARS = 4;
  localparam int REG_NAME_W     = REG_NAME_CHARS * 8;
  localparam int MNEMONIC_CHARS = 6;
  localparam int MNEMONIC_W     = MNEMONIC_CHARS * 8;
  localparam int IMM_W          = 32;
  localparam int FLAG_W         = 8;
  localparam int OPCODE_W       = 7;

  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [FORMAT_W-1:0]   instr_format_t;
  typedef logic [REG_NUM_W-1:0]  reg_num_t;
  typedef logic [REG_NAME_W-1:0] reg_name_t;
  typedef logic [MNEMONIC_W-1:0] mnemonic_t;
  typedef logic [IMM_W-1:0]      imm_t;
  typedef logic [FLAG_W-1:0]     disasm_flag_t;

  ////////////////////////////////////////////////////////////
  // instruction formats
  ////////////////////////////////////////////////////////////

  localparam instr_format_t FMT_R       = 3'd0;
  localparam instr_format_t FMT_I       = 3'd1;
  localparam instr_format_t FMT_S       = 3'd2;
  localparam instr_format_t FMT_SB      = 3'd3;
  localparam instr_format_t FMT_U       = 3'd4;
  localparam instr_format_t FMT_UJ      = 3'd5;
  localparam instr_format_t FMT_ILLEGAL = 3'd7;

  ////////////////////////////////////////////////////////////
  // flag byte
  ////////////////////////////////////////////////////////////

  localparam int FLAG_RD_INDEX      = 0;
  localparam int FLAG_RS1_INDEX     = 1;
  localparam int FLAG_RS2_INDEX     = 2;
  localparam int FLAG_IMM_INDEX     = 3;
  localparam int FLAG_DIFF_INDEX    = 4;
  localparam int FLAG_SIGNED_INDEX  = 5;
  localparam int FLAG_BRACKET_INDEX = 6;
  localparam int FLAG_LOAD_INDEX    = 7;

  // presence masks are ordered imm, rs2, rs1, rd from bit 3 down.
  localparam logic [3:0] PRESENCE_R = 4'b0111;
  localparam logic [3:0] PRESENCE_I = 4'b1011;
  localparam logic [3:0] PRESENCE_S = 4'b1110;
  localparam logic [3:0] PRESENCE_U = 4'b1001;

  localparam mnemonic_t MNEMONIC_UNIMP = "unimp ";

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
